/* sources.f */
hw/eth_frame_pkg.sv
hw/cmd_pkg.sv
hw/cmd_rx_framer.sv
hw/cmd_exec.sv
hw/reply_tx.sv
hw/cmd_decoder_top.sv
tests/cmd_decoder_chk.sv
tests/cmd_decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal -f sources.f --top-module cmd_decoder_tb \
    -o cmd_decoder_sim \
    && ./obj_dir/cmd_decoder_sim > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
! grep -q "Simulation failed" sim.log

/* tests/cmd_decoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder_tb;
    import eth_frame_pkg::*;
    import cmd_pkg::*;

    localparam logic [31:0] fw_version = "V2.3";
    localparam logic [15:0] dem_delay_init = 16'd9;
    localparam mux_sel_t    mux_init = 3'b011;

    typedef struct packed {
        logic [15:0] dem_delay;
        gain_t       gain;
        logic [15:0] wfm_amplitude;
        logic        mode_raw_dem;
        mux_sel_t    mux_1;
        mux_sel_t    mux_2;
        logic [3:0]  ttl_control;
        logic        filter_order;
        alpha_t      alpha;
    } config_t;

    typedef struct packed {
        logic [3:0]  len;           // payload bytes in the frame
        logic [63:0] payload;       // byte 0 on top
        logic        dac_running;
        logic        adc_ready;
        logic        stall;         // random tx back-pressure
        reply_kind_e kind;
        config_t     cfg;           // registers after the reply
        logic [7:0]  starts;        // pulses seen so far
        logic [7:0]  stops;
    } test_t;

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    status_word_t rx_status = '0;
    logic         rx_status_empty = 1'b1;
    byte_t        rx_data = '0;
    logic         tx_data_full = 1'b0;
    logic         tx_status_full = 1'b0;
    logic         dac_running = 1'b0;
    logic         adc_ready = 1'b0;
    logic         rx_status_read;
    logic         rx_data_read;
    byte_t        tx_data;
    logic         tx_data_write;
    status_word_t tx_status;
    logic         tx_status_write;
    logic         start_dac_cmd;
    logic         stop_dac_cmd;
    logic [15:0]  dem_delay;
    gain_t        gain;
    logic [15:0]  wfm_amplitude;
    logic         mode_raw_dem;
    mux_sel_t     mux_1;
    mux_sel_t     mux_2;
    logic [3:0]   ttl_control;
    logic         filter_order;
    alpha_t       alpha;

    status_word_t rx_status_q[$];
    byte_t        rx_data_q[$];
    byte_t        tx_bytes[$];
    status_word_t tx_status_q[$];
    test_t        tests[$];
    string        names[$];
    config_t      cur;
    config_t      reset_cfg;
    logic         stall_en = 1'b0;
    int           exp_starts = 0;
    int           exp_stops = 0;
    int           start_count = 0;
    int           stop_count = 0;
    int           cycle_count = 0;
    int           cycle_limit = 100000;
    int           errors = 0;
    int           passed = 0;

    cmd_decoder_top #(
        .fw_version(fw_version), .dem_delay_init(dem_delay_init), .mux_init(mux_init)
    ) u_dut (.*);

    always #2 clk = ~clk;

    // fifo side effects of the strobes seen at this edge
    always @(posedge clk) begin
        if (rx_status_read) void'(rx_status_q.pop_front());
        if (rx_data_read) void'(rx_data_q.pop_front());
        if (tx_data_write) tx_bytes.push_back(tx_data);
        if (tx_status_write) tx_status_q.push_back(tx_status);
        if (start_dac_cmd) start_count++;
        if (stop_dac_cmd) stop_count++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: no reply within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic drive_inputs();
        rx_status_empty = (rx_status_q.size() == 0);
        rx_status = (rx_status_q.size() > 0) ? rx_status_q[0] : '0;      // show-ahead
        rx_data = (rx_data_q.size() > 0) ? rx_data_q[0] : 8'h00;
        tx_data_full = stall_en && ($urandom % 3 == 0);
        tx_status_full = stall_en && ($urandom % 4 == 0);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        drive_inputs();
    endtask

    function automatic config_t read_config();
        config_t c;
        c.dem_delay = dem_delay;
        c.gain = gain;
        c.wfm_amplitude = wfm_amplitude;
        c.mode_raw_dem = mode_raw_dem;
        c.mux_1 = mux_1;
        c.mux_2 = mux_2;
        c.ttl_control = ttl_control;
        c.filter_order = filter_order;
        c.alpha = alpha;
        return c;
    endfunction

    task automatic add_test(input string name, input int len, input logic [31:0] code,
                            input logic [31:0] data, input logic dac, input logic adc,
                            input logic stall, input reply_kind_e kind);
        test_t t;
        t.len = 4'(len);
        t.payload = {code, data};
        t.dac_running = dac;
        t.adc_ready = adc;
        t.stall = stall;
        t.kind = kind;
        t.cfg = cur;
        t.starts = 8'(exp_starts);
        t.stops = 8'(exp_stops);
        tests.push_back(t);
        names.push_back(name);
    endtask

    task automatic check_reply(input string name, input reply_kind_e kind, input logic [63:0] got,
                               input int got_n, input status_word_t got_st,
                               input status_word_t req);
        logic [63:0] exp;
        int          exp_n;
        case (kind)
            rk_ack:  exp = {24'h0, "ACK", 16'h0d0a};
            rk_nak:  exp = {24'h0, "NAK", 16'h0d0a};
            rk_err:  exp = {24'h0, "ERR", 16'h0d0a};
            default: exp = {16'h0, fw_version, 16'h0d0a};
        endcase
        exp_n = (kind == rk_ver) ? 6 : 5;
        if (got_n != exp_n || got != exp) begin
            $display("Fail at %0t: %s reply got %0d bytes %h expected %0d bytes %h",
                     $time, name, got_n, got, exp_n, exp);
            errors++;
        end
        if (got_st.len != 16'(exp_n) || got_st.ip != req.ip || got_st.mac != req.mac) begin
            $display("Fail at %0t: %s tx status got %h expected len %0d ip %h mac %h",
                     $time, name, got_st, exp_n, req.ip, req.mac);
            errors++;
        end
    endtask

    task automatic check_config(input string name, input config_t got, input config_t exp);
        if (got != exp) begin
            $display("Fail at %0t: %s config got %p expected %p", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int got,
                               input int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s %s got %0d expected %0d", $time, name, what, got, exp);
            errors++;
        end
    endtask

    task automatic build_table();
        logic [31:0] d;
        cur = '0;
        cur.dem_delay = dem_delay_init;
        cur.mux_1 = mux_init;
        cur.mux_2 = mux_init;
        reset_cfg = cur;
        d = $urandom();
        cur.dem_delay = d[15:0];                    // low half
        add_test("dely write", 8, "DELY", d, 1'b0, 1'b0, 1'b0, rk_ack);
        d = $urandom();
        cur.gain = d[2:0];
        add_test("gain write", 8, "GAIN", d, 1'b0, 1'b0, 1'b0, rk_ack);
        d = $urandom();
        cur.wfm_amplitude = d[15:0];
        add_test("wfma write", 8, "WFMA", d, 1'b0, 1'b0, 1'b0, rk_ack);
        d = $urandom();
        cur.alpha = d[26:0];
        add_test("alph write", 8, "ALPH", d, 1'b0, 1'b0, 1'b0, rk_ack);
        cur.mux_1 = 3'd1;                           // lo[2:0]
        cur.mux_2 = 3'd6;                           // hi[2:0]
        add_test("mxcn split", 8, "MXCN", {16'h1236, 16'h0a01}, 1'b0, 1'b0, 1'b0, rk_ack);
        cur.ttl_control = 4'b1001;                  // hi bits above lo bits
        add_test("ttlc split", 8, "TTLC", {16'h00f2, 16'h0031}, 1'b0, 1'b0, 1'b0, rk_ack);
        add_test("dely no data", 4, "DELY", 32'h0, 1'b0, 1'b0, 1'b0, rk_err);
        add_test("six bytes", 6, "DELY", 32'h1234_5678, 1'b0, 1'b0, 1'b0, rk_nak);
        add_test("unknown code", 8, "QQQQ", 32'h1, 1'b0, 1'b0, 1'b0, rk_nak);
        exp_starts++;
        add_test("dacg start", 4, "DACG", 32'h0, 1'b0, 1'b1, 1'b0, rk_ack);
        add_test("dacg running", 4, "DACG", 32'h0, 1'b1, 1'b1, 1'b0, rk_err);
        add_test("dacs idle", 4, "DACS", 32'h0, 1'b0, 1'b1, 1'b0, rk_err);
        exp_stops++;
        add_test("dacs stop", 4, "DACS", 32'h0, 1'b1, 1'b1, 1'b0, rk_ack);
        add_test("acmd mixed", 8, "ACMD", 32'h00ff_0000, 1'b0, 1'b0, 1'b0, rk_err);
        cur.mode_raw_dem = 1'b1;
        add_test("acmd ones", 8, "ACMD", 32'hffff_ffff, 1'b0, 1'b0, 1'b0, rk_ack);
        cur.filter_order = 1'b1;
        add_test("ordr ones", 8, "ORDR", 32'hffff_ffff, 1'b0, 1'b0, 1'b0, rk_ack);
        cur.filter_order = 1'b0;                    // one clear bit is enough
        add_test("ordr mixed", 8, "ORDR", 32'hffff_7fff, 1'b0, 1'b0, 1'b0, rk_ack);
        add_test("version", 4, "VER?", 32'h0, 1'b0, 1'b0, 1'b0, rk_ver);
        d = $urandom();
        cur.dem_delay = d[15:0];
        add_test("dely stalled", 8, "DELY", d, 1'b0, 1'b0, 1'b1, rk_ack);
        add_test("version stalled", 4, "VER?", 32'h0, 1'b0, 1'b0, 1'b1, rk_ver);
        add_test("nak stalled", 5, "GAIN", 32'h0, 1'b0, 1'b0, 1'b1, rk_nak);
    endtask

    initial begin
        test_t        t;
        status_word_t req;
        logic [63:0]  got;
        int           errors_before;
        void'($urandom(44008));
        build_table();
        cycle_limit = 200 * tests.size() + 50;          // margin for reset
        repeat (5) @(negedge clk);
        reset = 1'b0;
        next_cycle();
        check_config("reset values", read_config(), reset_cfg);
        foreach (tests[i]) begin
            t = tests[i];
            errors_before = errors;
            req.len = 16'(t.len);
            req.ip = 32'hc0a8_0a00 + 32'(i);            // new sender per frame
            req.mac = 48'h0200_5e10_0000 + 48'(i * 257);
            dac_running = t.dac_running;
            adc_ready = t.adc_ready;
            stall_en = t.stall;
            for (int b = 0; b < int'(t.len); b++) begin
                rx_data_q.push_back(t.payload[63 - 8*b -: 8]);
            end
            rx_status_q.push_back(req);
            drive_inputs();
            while (tx_status_q.size() == 0) begin
                next_cycle();
            end
            got = '0;
            foreach (tx_bytes[k]) begin
                got = {got[55:0], tx_bytes[k]};
            end
            check_reply(names[i], t.kind, got, tx_bytes.size(), tx_status_q[0], req);
            check_config(names[i], read_config(), t.cfg);
            check_count(names[i], "start pulses", start_count, int'(t.starts));
            check_count(names[i], "stop pulses", stop_count, int'(t.stops));
            check_count(names[i], "rx bytes left", rx_data_q.size(), 0);
            tx_bytes.delete();
            tx_status_q.delete();
            if (errors == errors_before) begin
                passed++;
                $display("test %0d %s: ok", i, names[i]);
            end else begin
                $display("test %0d %s: FAILED", i, names[i]);
            end
        end
        $display("%0d tests, %0d passed, %0d errors", tests.size(), passed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/cmd_decoder_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder_chk (
    input  logic clk,
    input  logic reset,
    input  logic rx_status_read,
    input  logic rx_status_empty,
    input  logic tx_data_write,
    input  logic tx_data_full,
    input  logic start_dac_cmd,
    input  logic stop_dac_cmd
);

    data_write_not_full: assert property (
        @(posedge clk) disable iff (reset) tx_data_write |-> !tx_data_full
    ) else $error("tx_data_write while tx data FIFO is full");

    status_read_not_empty: assert property (
        @(posedge clk) disable iff (reset) rx_status_read |-> !rx_status_empty
    ) else $error("rx_status_read while rx status FIFO is empty");

    // dac commands are single cycle strobes
    start_one_cycle: assert property (
        @(posedge clk) disable iff (reset) start_dac_cmd |=> !start_dac_cmd
    ) else $error("start_dac_cmd longer than one cycle");

    stop_one_cycle: assert property (
        @(posedge clk) disable iff (reset) stop_dac_cmd |=> !stop_dac_cmd
    ) else $error("stop_dac_cmd longer than one cycle");

endmodule

bind cmd_decoder_top cmd_decoder_chk u_chk (
    .clk(clk), .reset(reset),
    .rx_status_read(rx_status_read), .rx_status_empty(rx_status_empty),
    .tx_data_write(tx_data_write), .tx_data_full(tx_data_full),
    .start_dac_cmd(start_dac_cmd), .stop_dac_cmd(stop_dac_cmd)
);

`default_nettype wire

/* hw/cmd_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder_top #(
    parameter logic [31:0]       fw_version = "1.0A",
    parameter logic [15:0]       dem_delay_init = 16'd1,
    parameter cmd_pkg::mux_sel_t mux_init = 3'b100
) (
    input  logic                        clk,
    input  logic                        reset,
    input  eth_frame_pkg::status_word_t rx_status,
    input  logic                        rx_status_empty,
    output logic                        rx_status_read,
    input  eth_frame_pkg::byte_t        rx_data,
    output logic                        rx_data_read,
    output eth_frame_pkg::byte_t        tx_data,
    output logic                        tx_data_write,
    input  logic                        tx_data_full,
    output eth_frame_pkg::status_word_t tx_status,
    output logic                        tx_status_write,
    input  logic                        tx_status_full,
    input  logic                        dac_running,
    input  logic                        adc_ready,
    output logic                        start_dac_cmd,
    output logic                        stop_dac_cmd,
    output logic [15:0]                 dem_delay,
    output cmd_pkg::gain_t              gain,
    output logic [15:0]                 wfm_amplitude,
    output logic                        mode_raw_dem,
    output cmd_pkg::mux_sel_t           mux_1,
    output cmd_pkg::mux_sel_t           mux_2,
    output logic [3:0]                  ttl_control,
    output logic                        filter_order,
    output cmd_pkg::alpha_t             alpha
);
    import eth_frame_pkg::*;
    import cmd_pkg::*;

    logic             reply_busy;
    logic [ip_w-1:0]  source_ip;
    logic [mac_w-1:0] source_mac;
    logic             cmd_valid;
    logic [31:0]      cmd_word;
    data_word_u       data_word;
    logic             with_data;
    logic             length_bad;
    logic             reply_valid;
    reply_kind_e      reply_kind;

    cmd_rx_framer u_framer (
        .clk(clk), .reset(reset),
        .rx_status(rx_status), .rx_status_empty(rx_status_empty),
        .rx_status_read(rx_status_read),
        .rx_data(rx_data), .rx_data_read(rx_data_read),
        .reply_busy(reply_busy),
        .source_ip(source_ip), .source_mac(source_mac),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word), .data_word(data_word),
        .with_data(with_data), .length_bad(length_bad)
    );

    cmd_exec #(.dem_delay_init(dem_delay_init), .mux_init(mux_init)) u_exec (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word), .data_word(data_word),
        .with_data(with_data), .length_bad(length_bad),
        .dac_running(dac_running), .adc_ready(adc_ready),
        .reply_valid(reply_valid), .reply_kind(reply_kind),
        .start_dac_cmd(start_dac_cmd), .stop_dac_cmd(stop_dac_cmd),
        .dem_delay(dem_delay), .gain(gain), .wfm_amplitude(wfm_amplitude),
        .mode_raw_dem(mode_raw_dem), .mux_1(mux_1), .mux_2(mux_2),
        .ttl_control(ttl_control), .filter_order(filter_order), .alpha(alpha)
    );

    reply_tx #(.fw_version(fw_version)) u_reply (
        .clk(clk), .reset(reset),
        .reply_valid(reply_valid), .reply_kind(reply_kind),
        .source_ip(source_ip), .source_mac(source_mac),
        .reply_busy(reply_busy),
        .tx_data(tx_data), .tx_data_write(tx_data_write), .tx_data_full(tx_data_full),
        .tx_status(tx_status), .tx_status_write(tx_status_write),
        .tx_status_full(tx_status_full)
    );

endmodule

`default_nettype wire

/* hw/reply_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_tx #(
    parameter logic [31:0] fw_version = "1.0A"
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             reply_valid,
    input  eth_frame_pkg::reply_kind_e       reply_kind,
    input  logic [eth_frame_pkg::ip_w-1:0]   source_ip,
    input  logic [eth_frame_pkg::mac_w-1:0]  source_mac,
    output logic                             reply_busy,
    output eth_frame_pkg::byte_t             tx_data,
    output logic                             tx_data_write,
    input  logic                             tx_data_full,
    output eth_frame_pkg::status_word_t      tx_status,
    output logic                             tx_status_write,
    input  logic                             tx_status_full
);
    import eth_frame_pkg::*;

    localparam byte_t cr = 8'h0d;
    localparam byte_t lf = 8'h0a;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_status
    } state_t;

    state_t      state;
    logic [47:0] tx_buf;        // next byte in the top 8 bits
    logic [2:0]  tx_left;
    logic        reply_long;    // version reply, 6 bytes

    assign reply_busy = reply_valid || (state != st_idle);

    assign tx_data = tx_buf[47:40];
    assign tx_data_write = (state == st_data) && !tx_data_full;   // hold byte while full

    assign tx_status.len = reply_long ? len_w'(6) : len_w'(5);
    assign tx_status.ip = source_ip;
    assign tx_status.mac = source_mac;
    assign tx_status_write = (state == st_status) && !tx_status_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            tx_left <= '0;
            reply_long <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (reply_valid) begin
                        reply_long <= (reply_kind == rk_ver);
                        tx_left <= (reply_kind == rk_ver) ? 3'd6 : 3'd5;
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (tx_data_write) begin
                        tx_left <= tx_left - 1'b1;
                        if (tx_left == 3'd1) state <= st_status;
                    end
                end
                default: begin
                    if (tx_status_write) state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && reply_valid) begin
            case (reply_kind)
                rk_ack: tx_buf <= {"ACK", cr, lf, 8'h00};
                rk_nak: tx_buf <= {"NAK", cr, lf, 8'h00};
                rk_err: tx_buf <= {"ERR", cr, lf, 8'h00};
                default: tx_buf <= {fw_version, cr, lf};
            endcase
        end else if (tx_data_write) begin
            tx_buf <= {tx_buf[39:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_exec #(
    parameter logic [15:0]       dem_delay_init = 16'd1,
    parameter cmd_pkg::mux_sel_t mux_init = 3'b100
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cmd_valid,
    input  logic [31:0]                cmd_word,
    input  cmd_pkg::data_word_u        data_word,
    input  logic                       with_data,
    input  logic                       length_bad,
    input  logic                       dac_running,   // fast dac in steady state
    input  logic                       adc_ready,
    output logic                       reply_valid,
    output eth_frame_pkg::reply_kind_e reply_kind,
    output logic                       start_dac_cmd,
    output logic                       stop_dac_cmd,
    output logic [15:0]                dem_delay,
    output cmd_pkg::gain_t             gain,
    output logic [15:0]                wfm_amplitude,
    output logic                       mode_raw_dem,
    output cmd_pkg::mux_sel_t          mux_1,
    output cmd_pkg::mux_sel_t          mux_2,
    output logic [3:0]                 ttl_control,
    output logic                       filter_order,
    output cmd_pkg::alpha_t            alpha
);
    import eth_frame_pkg::*;
    import cmd_pkg::*;

    logic data_uniform;     // all ones or all zeros

    assign data_uniform = (&data_word.raw) || (~|data_word.raw);

    always_ff @(posedge clk) begin
        if (reset) begin
            reply_valid <= 1'b0;
            reply_kind <= rk_ack;
            start_dac_cmd <= 1'b0;
            stop_dac_cmd <= 1'b0;
            dem_delay <= dem_delay_init;
            gain <= '0;
            wfm_amplitude <= '0;
            mode_raw_dem <= 1'b0;
            mux_1 <= mux_init;
            mux_2 <= mux_init;
            ttl_control <= '0;
            filter_order <= 1'b0;
            alpha <= '0;
        end else begin
            reply_valid <= cmd_valid;
            start_dac_cmd <= 1'b0;      // one cycle pulses
            stop_dac_cmd <= 1'b0;
            if (cmd_valid) begin
                reply_kind <= rk_ack;
                if (length_bad) begin
                    reply_kind <= rk_nak;
                end else begin
                    case (cmd_word)
                        cmd_ver: reply_kind <= rk_ver;
                        cmd_dacg: begin
                            if (!dac_running && adc_ready) start_dac_cmd <= 1'b1;
                            else reply_kind <= rk_err;
                        end
                        cmd_dacs: begin
                            if (dac_running) stop_dac_cmd <= 1'b1;
                            else reply_kind <= rk_err;
                        end
                        cmd_dely: begin
                            if (with_data) dem_delay <= data_word.halves.lo;
                            else reply_kind <= rk_err;
                        end
                        cmd_gain: begin
                            if (with_data) gain <= data_word.halves.lo[2:0];
                            else reply_kind <= rk_err;
                        end
                        cmd_wfma: begin
                            if (with_data) wfm_amplitude <= data_word.halves.lo;
                            else reply_kind <= rk_err;
                        end
                        cmd_acmd: begin
                            if (!dac_running && data_uniform) begin
                                mode_raw_dem <= data_word.raw[31];  // high for demodulation
                            end else begin
                                reply_kind <= rk_err;
                            end
                        end
                        cmd_mxcn: begin
                            mux_1 <= data_word.halves.lo[2:0];
                            mux_2 <= data_word.halves.hi[2:0];
                        end
                        cmd_ttlc: begin
                            ttl_control <= {data_word.halves.hi[1:0], data_word.halves.lo[1:0]};
                        end
                        cmd_alph: alpha <= data_word.raw[26:0];
                        cmd_ordr: filter_order <= &data_word.raw;
                        default: reply_kind <= rk_nak;  // unknown code
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_rx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_rx_framer (
    input  logic                             clk,
    input  logic                             reset,
    input  eth_frame_pkg::status_word_t      rx_status,
    input  logic                             rx_status_empty,
    output logic                             rx_status_read,
    input  eth_frame_pkg::byte_t             rx_data,
    output logic                             rx_data_read,
    input  logic                             reply_busy,
    output logic [eth_frame_pkg::ip_w-1:0]   source_ip,
    output logic [eth_frame_pkg::mac_w-1:0]  source_mac,
    output logic                             cmd_valid,
    output logic [31:0]                      cmd_word,
    output cmd_pkg::data_word_u              data_word,
    output logic                             with_data,
    output logic                             length_bad
);
    import eth_frame_pkg::*;
    import cmd_pkg::*;

    localparam int buf_w = len_cmd_data * $bits(byte_t);

    typedef enum logic [1:0] {
        st_idle,
        st_recv,        // consumes or flushes payload bytes
        st_done
    } state_t;

    state_t           state;
    logic [len_w-1:0] byte_cnt;     // bytes still to read
    logic [buf_w-1:0] rx_buf;

    // show-ahead FIFOs, so the word is valid in the cycle it is popped
    assign rx_status_read = (state == st_idle) && !rx_status_empty && !reply_busy;
    assign rx_data_read = (state == st_recv);

    assign cmd_valid = (state == st_done);
    assign cmd_word = with_data ? rx_buf[buf_w-1 -: 32] : rx_buf[31:0];
    assign data_word.raw = with_data ? rx_buf[31:0] : 32'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            byte_cnt <= '0;
            with_data <= 1'b0;
            length_bad <= 1'b0;
            source_ip <= '0;
            source_mac <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (rx_status_read) begin
                        byte_cnt <= rx_status.len;
                        source_ip <= rx_status.ip;      // reply goes to the last sender
                        source_mac <= rx_status.mac;
                        with_data <= (rx_status.len == len_w'(len_cmd_data));
                        length_bad <= (rx_status.len != len_w'(len_cmd_only)) &&
                                      (rx_status.len != len_w'(len_cmd_data));
                        if (rx_status.len == '0) begin
                            state <= st_done;           // nothing to flush
                        end else begin
                            state <= st_recv;
                        end
                    end
                end
                st_recv: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (byte_cnt == len_w'(1)) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // first byte ends up in the top byte after a full frame
    always_ff @(posedge clk) begin
        if (rx_data_read) begin
            rx_buf <= {rx_buf[buf_w-9:0], rx_data};
        end
    end

endmodule

`default_nettype wire

/* hw/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

    // four ascii characters, first character in the top byte
    typedef enum logic [31:0] {
        cmd_ver  = "VER?",
        cmd_dacg = "DACG",          // dac go
        cmd_dacs = "DACS",          // dac stop
        cmd_dely = "DELY",          // dac to adc latency
        cmd_gain = "GAIN",
        cmd_wfma = "WFMA",          // waveform amplitude, q0.16
        cmd_acmd = "ACMD",          // raw or demodulated acquisition
        cmd_mxcn = "MXCN",          // input mux config
        cmd_ttlc = "TTLC",
        cmd_ordr = "ORDR",          // filter order
        cmd_alph = "ALPH"           // filter alpha
    } cmd_code_e;

    localparam int len_cmd_only = 4;
    localparam int len_cmd_data = 8;

    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } data_halves_t;

    // mxcn, ttlc and dely read the halves, acmd and ordr the whole word
    typedef union packed {
        logic [31:0]  raw;
        data_halves_t halves;
    } data_word_u;

    typedef logic [2:0] gain_t;
    typedef logic [2:0] mux_sel_t;
    typedef logic [26:0] alpha_t;

endpackage

`default_nettype wire

/* hw/eth_frame_pkg.sv */
`default_nettype none

package eth_frame_pkg;

    localparam int mac_w = 48;
    localparam int ip_w = 32;
    localparam int len_w = 16;

    typedef logic [7:0] byte_t;

    // layout of one entry in the rx and tx status FIFOs
    typedef struct packed {
        logic [len_w-1:0] len;      // udp payload bytes
        logic [ip_w-1:0]  ip;
        logic [mac_w-1:0] mac;
    } status_word_t;

    typedef enum logic [1:0] {
        rk_ack,
        rk_nak,
        rk_err,
        rk_ver                      // version string instead of a short word
    } reply_kind_e;

endpackage

`default_nettype wire
